// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    localparam int addr_len = 32;
    localparam int data_len = 32;

    // fetch starts here after reset.
    localparam logic [addr_len-1:0] reset_pc = '0;

    // fault flags returned by instruction memory together with the data.
    typedef struct packed {
        logic page_fault;
        logic xes_fault;
    } mem_fault_t;

    typedef logic [3:0] cause_t;

    // misaligned shares code 0 with "no fault"; the packet fault bit tells them apart.
    localparam cause_t cause_none       = 4'd0;
    localparam cause_t cause_misaligned = 4'd0;
    localparam cause_t cause_access     = 4'd1;
    localparam cause_t cause_page       = 4'd12;

    typedef struct packed {
        logic [addr_len-1:0] pc;
        logic [data_len-1:0] inst;
        logic                fault;
        cause_t              cause;
    } fetch_pkt_t;

endpackage

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    // one redirect source as raised by the later pipeline stages.
    typedef struct packed {
        logic                           en;
        logic [fetch_pkg::addr_len-1:0] addr;
    } redirect_src_t;

    // all redirect sources, listed from highest to lowest priority.
    typedef struct packed {
        redirect_src_t restart;
        redirect_src_t eret;
        redirect_src_t irq;
        redirect_src_t alu;
        redirect_src_t jump;
    } redirect_req_t;

    // the merged redirect seen by the fetch unit.
    typedef struct packed {
        logic                           valid;
        logic [fetch_pkg::addr_len-1:0] target;
    } redirect_t;

endpackage

// ==== hdl/redirect_arbiter.sv ====
`timescale 1ns/1ps

module redirect_arbiter (
    input  ctrl_pkg::redirect_req_t req,
    input  logic                    attach,
    output ctrl_pkg::redirect_t     redirect
);

    import fetch_pkg::*;
    import ctrl_pkg::*;

    redirect_src_t irq_gated;
    redirect_src_t winner;

    // interrupts are held off while a debugger owns the core.
    always_comb begin
        irq_gated    = req.irq;
        irq_gated.en = req.irq.en & ~attach;
    end

    always_comb begin
        if (req.restart.en) begin
            winner = req.restart;
        end else if (req.eret.en) begin
            winner = req.eret;
        end else if (irq_gated.en) begin
            winner = irq_gated;
        end else if (req.alu.en) begin
            winner = req.alu;
        end else begin
            winner = req.jump;
        end
    end

    // the jump source is the fallback, so its enable is low when nothing is active.
    assign redirect.valid  = winner.en;

    // instructions are at least halfword aligned, so bit 0 never reaches the pc.
    assign redirect.target = {winner.addr[addr_len-1:1], 1'b0};

endmodule

// ==== hdl/ifu.sv ====
`timescale 1ns/1ps

module ifu (
    input  logic                           clk,
    input  logic                           rstn,
    input  ctrl_pkg::redirect_t            redirect,
    output logic                           imem_req,
    output logic [fetch_pkg::addr_len-1:0] imem_addr,
    input  logic [fetch_pkg::data_len-1:0] imem_rdata,
    input  fetch_pkg::mem_fault_t          imem_fault,
    input  logic                           imem_busy,
    output logic [fetch_pkg::addr_len-1:0] pc,
    output logic [fetch_pkg::data_len-1:0] inst,
    output logic                           inst_valid,
    output logic                           misaligned,
    output fetch_pkg::mem_fault_t          fault,
    input  logic                           stall,
    input  logic                           attach,
    input  logic                           dbg_exec,
    input  logic [fetch_pkg::data_len-1:0] dbg_inst
);

    import fetch_pkg::*;

    logic                jump;
    logic [addr_len-1:0] pc_d1;
    logic [addr_len-1:0] pc_d2;
    logic                req_pending;
    logic                hold_valid;
    logic [data_len-1:0] hold_inst;
    mem_fault_t          hold_fault;
    logic                mis_pending;
    logic                mem_ready;
    logic                fetch_fire;
    logic                mis_fire;
    logic                dbg_fire;

    assign jump = redirect.valid;

    // an instruction is ready when memory returns it now or one was parked earlier.
    assign mem_ready  = (req_pending & ~imem_busy) | hold_valid;
    assign fetch_fire = mem_ready & ~stall & ~jump & ~attach;
    assign mis_fire   = mis_pending & ~stall & ~jump & ~attach;
    assign dbg_fire   = attach & dbg_exec & ~stall & ~jump;

    // a new request goes out as the previous one is handed on, so fetch streams.
    // a pc with bit 1 set is never sent to memory; fetch waits for the next redirect.
    // nothing is requested while reset is held.
    assign imem_req = rstn & ~imem_busy & ~jump & ~attach & ~pc_d1[1] &
                      (fetch_fire | ~req_pending);

    // pc_d1 is the address of the next request.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_d1 <= reset_pc;
        end else if (jump) begin
            pc_d1 <= redirect.target;
        end else if (imem_req) begin
            pc_d1 <= pc_d1 + addr_len'(4);
        end
    end

    // pc_d2 follows the instruction that is next to be handed to decode.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_d2 <= reset_pc;
        end else if (jump) begin
            pc_d2 <= redirect.target;
        end else if (fetch_fire) begin
            pc_d2 <= pc_d1;
        end
    end

    // a redirect abandons the request in flight; its late data is then ignored.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_pending <= 1'b0;
        end else if (imem_req) begin
            req_pending <= 1'b1;
        end else if (fetch_fire | jump) begin
            req_pending <= 1'b0;
        end
    end

    // data that comes back while it cannot be handed on is parked here.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_valid <= 1'b0;
        end else if (fetch_fire | jump) begin
            hold_valid <= 1'b0;
        end else if (req_pending & ~imem_busy) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_pending & ~imem_busy & ~hold_valid) begin
            hold_inst  <= imem_rdata;
            hold_fault <= imem_fault;
        end
    end

    // a misaligned target is reported once, one cycle after the redirect.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mis_pending <= 1'b0;
        end else if (jump) begin
            mis_pending <= redirect.target[1];
        end else if (mis_fire) begin
            mis_pending <= 1'b0;
        end
    end

    assign imem_addr  = pc_d1;
    assign pc         = pc_d2;
    assign inst_valid = fetch_fire | mis_fire | dbg_fire;
    assign misaligned = mis_pending & ~attach;

    always_comb begin
        if (attach) begin
            inst = dbg_inst;
        end else if (hold_valid) begin
            inst = hold_inst;
        end else if (mis_pending) begin
            inst = '0;
        end else begin
            inst = imem_rdata;
        end
    end

    // debugger instructions and misaligned targets never carry memory faults.
    always_comb begin
        if (attach | mis_pending) begin
            fault = '0;
        end else if (hold_valid) begin
            fault = hold_fault;
        end else begin
            fault = imem_fault;
        end
    end

endmodule

// ==== hdl/fetch_issue.sv ====
`timescale 1ns/1ps

module fetch_issue (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [fetch_pkg::addr_len-1:0] pc,
    input  logic [fetch_pkg::data_len-1:0] inst,
    input  logic                           inst_valid,
    input  logic                           misaligned,
    input  fetch_pkg::mem_fault_t          fault,
    input  logic                           stall,
    input  logic                           flush,
    output fetch_pkg::fetch_pkt_t          dec_pkt,
    output logic                           dec_valid
);

    import fetch_pkg::*;

    cause_t     cause;
    fetch_pkt_t pkt_nxt;

    // misaligned wins over page fault, which wins over access fault.
    always_comb begin
        if (misaligned) begin
            cause = cause_misaligned;
        end else if (fault.page_fault) begin
            cause = cause_page;
        end else if (fault.xes_fault) begin
            cause = cause_access;
        end else begin
            cause = cause_none;
        end
    end

    always_comb begin
        pkt_nxt.pc    = pc;
        pkt_nxt.inst  = inst;
        pkt_nxt.fault = misaligned | fault.page_fault | fault.xes_fault;
        pkt_nxt.cause = cause;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_pkt <= pkt_nxt;
        end
    end

    // flush drops the held packet even when decode is stalled.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= inst_valid;
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                           clk,
    input  logic                           rstn,
    input  ctrl_pkg::redirect_req_t        redirect_req,
    output logic                           imem_req,
    output logic [fetch_pkg::addr_len-1:0] imem_addr,
    input  logic [fetch_pkg::data_len-1:0] imem_rdata,
    input  fetch_pkg::mem_fault_t          imem_fault,
    input  logic                           imem_busy,
    input  logic                           stall,
    input  logic                           flush,
    input  logic                           attach,
    input  logic                           dbg_exec,
    input  logic [fetch_pkg::data_len-1:0] dbg_inst,
    output fetch_pkg::fetch_pkt_t          dec_pkt,
    output logic                           dec_valid
);

    import fetch_pkg::*;
    import ctrl_pkg::*;

    redirect_t           redirect;
    logic [addr_len-1:0] pc;
    logic [data_len-1:0] inst;
    logic                inst_valid;
    logic                misaligned;
    mem_fault_t          fault;

    redirect_arbiter redirect_arbiter_inst (
        .req      (redirect_req),
        .attach   (attach),
        .redirect (redirect)
    );

    ifu ifu_inst (
        .clk        (clk),
        .rstn       (rstn),
        .redirect   (redirect),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_fault (imem_fault),
        .imem_busy  (imem_busy),
        .pc         (pc),
        .inst       (inst),
        .inst_valid (inst_valid),
        .misaligned (misaligned),
        .fault      (fault),
        .stall      (stall),
        .attach     (attach),
        .dbg_exec   (dbg_exec),
        .dbg_inst   (dbg_inst)
    );

    // the issue register is the only place a flush takes effect.
    fetch_issue fetch_issue_inst (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (pc),
        .inst       (inst),
        .inst_valid (inst_valid),
        .misaligned (misaligned),
        .fault      (fault),
        .stall      (stall),
        .flush      (flush),
        .dec_pkt    (dec_pkt),
        .dec_valid  (dec_valid)
    );

endmodule

// ==== testbench/tb_imem_model.sv ====
`timescale 1ns/1ps

module tb_imem_model (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           req,
    input  logic [fetch_pkg::addr_len-1:0] addr,
    output logic [fetch_pkg::data_len-1:0] rdata,
    output fetch_pkg::mem_fault_t          fault,
    output logic                           busy
);

    import fetch_pkg::*;

    localparam logic [data_len-1:0] data_key = 32'hA5A5_0000;

    integer              seed = 32'h527;
    logic                pending;
    logic [1:0]          wait_cnt;
    logic [addr_len-1:0] addr_q;

    // a request is only taken while busy is low, which is also the cycle that returns data.
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending  <= 1'b0;
            wait_cnt <= 2'd0;
            addr_q   <= '0;
        end else if (req) begin
            pending  <= 1'b1;
            wait_cnt <= 2'($random(seed));
            addr_q   <= addr;
        end else if (pending && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            pending <= 1'b0;
        end
    end

    assign busy = pending && (wait_cnt != 2'd0);

    // every word is its own address scrambled, so a wrong fetch shows up in the data.
    assign rdata = addr_q ^ data_key;

    assign fault.page_fault = (addr_q[addr_len-1:12] == 20'h4);
    assign fault.xes_fault  = (addr_q[addr_len-1:12] == 20'h8);

endmodule

// ==== testbench/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;

    import fetch_pkg::*;
    import ctrl_pkg::*;

    localparam int mode_mem = 0;
    localparam int mode_mis = 1;
    localparam int mode_dbg = 2;
    localparam int st_run   = 0;
    localparam int st_mis   = 1;
    localparam int st_idle  = 2;

    logic                clk;
    logic                rstn;
    redirect_req_t       redirect_req;
    logic                imem_req;
    logic [addr_len-1:0] imem_addr;
    logic [data_len-1:0] imem_rdata;
    mem_fault_t          imem_fault;
    logic                imem_busy;
    logic                stall;
    logic                flush;
    logic                attach;
    logic                dbg_exec;
    logic [data_len-1:0] dbg_inst;
    fetch_pkt_t          dec_pkt;
    logic                dec_valid;

    // expected stream, kept by the comparing process.
    logic [addr_len-1:0] exp_pc = reset_pc;
    int                  stream = st_run;
    int                  pkt_mode = mode_mem;
    logic [data_len-1:0] pkt_dbg = '0;
    int                  taken = 0;
    int                  checks = 0;
    int                  cmp_errors = 0;

    int                  test_errors = 0;
    int                  errs;
    int                  tries;
    logic [addr_len-1:0] mis_addr = '1;
    fetch_pkt_t          snap_pkt;
    logic                snap_valid;
    redirect_req_t       req;

    fetch_top fetch_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .redirect_req (redirect_req),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .imem_fault   (imem_fault),
        .imem_busy    (imem_busy),
        .stall        (stall),
        .flush        (flush),
        .attach       (attach),
        .dbg_exec     (dbg_exec),
        .dbg_inst     (dbg_inst),
        .dec_pkt      (dec_pkt),
        .dec_valid    (dec_valid)
    );

    tb_imem_model imem_model_inst (
        .clk   (clk),
        .rstn  (rstn),
        .req   (imem_req),
        .addr  (imem_addr),
        .rdata (imem_rdata),
        .fault (imem_fault),
        .busy  (imem_busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic redirect_t pick_redirect(input redirect_req_t r, input logic att);
        redirect_src_t src;
        redirect_t     res;
        if (r.restart.en) begin
            src = r.restart;
        end else if (r.eret.en) begin
            src = r.eret;
        end else if (r.irq.en && !att) begin
            src = r.irq;
        end else if (r.alu.en) begin
            src = r.alu;
        end else begin
            src = r.jump;
        end
        res.valid  = src.en;
        res.target = src.addr & ~32'h1;
        return res;
    endfunction

    function automatic fetch_pkt_t ref_pkt(input logic [addr_len-1:0] at, input int mode,
                                           input logic [data_len-1:0] dbg_word);
        fetch_pkt_t p;
        logic       page;
        logic       xes;
        page = (at >= 32'h0000_4000) && (at <= 32'h0000_4fff);
        xes  = (at >= 32'h0000_8000) && (at <= 32'h0000_8fff);
        p.pc = at;
        if (mode == mode_dbg) begin
            p.inst  = dbg_word;
            p.fault = 1'b0;
            p.cause = cause_none;
        end else if (mode == mode_mis) begin
            p.inst  = '0;
            p.fault = 1'b1;
            p.cause = cause_misaligned;
        end else begin
            p.inst  = at ^ 32'hA5A5_0000;
            p.fault = page | xes;
            p.cause = page ? cause_page : (xes ? cause_access : cause_none);
        end
        return p;
    endfunction

    // a packet counts as consumed when the issue register moves on at the next edge.
    always @(negedge clk) begin : compare
        fetch_pkt_t exp;
        redirect_t  rd;
        if (rstn) begin
            if (dec_valid) begin
                checks++;
                if (pkt_mode == mode_dbg) begin
                    exp = ref_pkt(exp_pc, mode_dbg, pkt_dbg);
                end else begin
                    exp = ref_pkt(exp_pc, (stream == st_mis) ? mode_mis : mode_mem, '0);
                end
                assert (pkt_mode == mode_dbg || stream != st_idle) else begin
                    $display("a packet reached decode after a misaligned target");
                    cmp_errors++;
                end
                assert (dec_pkt == exp) else begin
                    $display("ERR dec_pkt expected %h got %h", exp, dec_pkt);
                    cmp_errors++;
                end
            end
            if (dec_valid && (!stall || flush)) begin
                taken++;
                if (pkt_mode != mode_dbg) begin
                    if (stream == st_mis) begin
                        stream = st_idle;
                    end else begin
                        exp_pc = exp_pc + 32'd4;
                    end
                end
            end
            if (!stall) begin
                pkt_mode = attach ? mode_dbg : mode_mem;
                pkt_dbg  = dbg_inst;
            end
            rd = pick_redirect(redirect_req, attach);
            if (rd.valid) begin
                exp_pc = rd.target;
                stream = rd.target[1] ? st_mis : st_run;
            end
            assert (!(imem_req && imem_addr == mis_addr)) else begin
                $display("a request was issued at the misaligned address %h", imem_addr);
                cmp_errors++;
            end
        end
    end

    task automatic pulse_redirect(input redirect_req_t r);
        @(posedge clk);
        redirect_req <= r;
        @(posedge clk);
        redirect_req <= '0;
    endtask

    task automatic jump_to(input logic [addr_len-1:0] target);
        redirect_req_t r;
        r      = '0;
        r.jump = '{en: 1'b1, addr: target};
        pulse_redirect(r);
    endtask

    task automatic wait_taken(input int n);
        int start;
        int cycles;
        start  = taken;
        cycles = 0;
        while (taken - start < n && cycles < 20 * n + 20) begin
            @(posedge clk);
            cycles++;
        end
        if (taken - start < n) begin
            $display("timeout: only %0d of %0d packets reached decode", taken - start, n);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (test_errors + cmp_errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors + cmp_errors - errs_before);
        end
    endtask

    initial begin
        rstn         <= 1'b0;
        redirect_req <= '0;
        stall        <= 1'b0;
        flush        <= 1'b0;
        attach       <= 1'b0;
        dbg_exec     <= 1'b0;
        dbg_inst     <= '0;
        repeat (4) @(posedge clk);
        assert (!imem_req && !dec_valid) else begin
            $display("imem_req or dec_valid went high during reset");
            test_errors++;
        end
        rstn <= 1'b1;

        errs = 0;
        wait_taken(12);
        report_test("sequential fetch", errs);

        errs = test_errors + cmp_errors;
        for (int lvl = 0; lvl < 5; lvl++) begin
            req         = '0;
            req.restart = '{en: (lvl == 0), addr: 32'h0000_1000};
            req.eret    = '{en: (lvl <= 1), addr: 32'h0000_2000};
            req.irq     = '{en: (lvl <= 2), addr: 32'h0000_3000};
            req.alu     = '{en: (lvl <= 3), addr: 32'h0000_5001};
            req.jump    = '{en: 1'b1, addr: 32'h0000_6000};
            pulse_redirect(req);
            wait_taken(3);
        end
        report_test("redirect priority", errs);

        // the second jump runs off the end of the access fault region.
        errs = test_errors + cmp_errors;
        jump_to(32'h0000_4000);
        wait_taken(3);
        jump_to(32'h0000_8ff8);
        wait_taken(4);
        report_test("memory faults", errs);

        errs = test_errors + cmp_errors;
        mis_addr = 32'h0000_7002;
        jump_to(32'h0000_7003);
        wait_taken(1);
        repeat (6) @(posedge clk);
        jump_to(32'h0000_0200);
        wait_taken(3);
        report_test("misaligned target", errs);

        errs = test_errors + cmp_errors;
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        snap_pkt   = dec_pkt;
        snap_valid = dec_valid;
        repeat (6) begin
            @(negedge clk);
            assert (dec_pkt == snap_pkt) else begin
                $display("ERR dec_pkt held %h now %h", snap_pkt, dec_pkt);
                test_errors++;
            end
            assert (dec_valid == snap_valid) else begin
                $display("ERR dec_valid held %h now %h", snap_valid, dec_valid);
                test_errors++;
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_taken(4);
        // let one packet at a time into the issue register until one is held there.
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        tries = 0;
        while (!dec_valid && tries < 20) begin
            @(posedge clk);
            stall <= 1'b0;
            @(posedge clk);
            stall <= 1'b1;
            @(negedge clk);
            tries++;
        end
        if (!dec_valid) begin
            $display("no packet was held in the issue register for the flush");
            test_errors++;
        end
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        assert (!dec_valid) else begin
            $display("the flushed packet is still valid");
            test_errors++;
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_taken(4);
        report_test("stall and flush", errs);

        errs = test_errors + cmp_errors;
        wait_taken(1);
        @(posedge clk);
        attach           <= 1'b1;
        redirect_req.irq <= '{en: 1'b1, addr: 32'h0000_9000};
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            dbg_exec <= 1'b1;
            dbg_inst <= {16'hD0B6, 16'(k)};
            @(posedge clk);
            dbg_exec <= 1'b0;
            wait_taken(1);
        end
        @(posedge clk);
        redirect_req <= '0;
        @(posedge clk);
        attach <= 1'b0;
        wait_taken(4);
        report_test("debug attach", errs);

        $display("checks %0d, packets %0d, errors %0d", checks, taken,
                 test_errors + cmp_errors);
        if (test_errors + cmp_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/fetch_pkg.sv
hdl/ctrl_pkg.sv
hdl/redirect_arbiter.sv
hdl/ifu.sv
hdl/fetch_issue.sv
hdl/fetch_top.sv
testbench/tb_imem_model.sv
testbench/tb_fetch_top.sv

// ==== Makefile ====
TOP = tb_fetch_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module fetch_top
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f compile.f --top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
